// ==== common/mips_pkg.sv ====
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 6;
    localparam int FUNC_W     = 6;

    // Opcodes
    localparam logic [OP_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OP_W-1:0] OP_JAL   = 6'b000011;
    localparam logic [OP_W-1:0] OP_BEQ   = 6'b000100;
    localparam logic [OP_W-1:0] OP_BNE   = 6'b000101;
    localparam logic [OP_W-1:0] OP_ADDIU = 6'b001001;
    localparam logic [OP_W-1:0] OP_SLTI  = 6'b001010;
    localparam logic [OP_W-1:0] OP_ANDI  = 6'b001100;
    localparam logic [OP_W-1:0] OP_ORI   = 6'b001101;
    localparam logic [OP_W-1:0] OP_XORI  = 6'b001110;
    localparam logic [OP_W-1:0] OP_LUI   = 6'b001111;
    localparam logic [OP_W-1:0] OP_LW    = 6'b100011;
    localparam logic [OP_W-1:0] OP_SW    = 6'b101011;

    // R-type function field
    localparam logic [FUNC_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [FUNC_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [FUNC_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [FUNC_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [FUNC_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [FUNC_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNC_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNC_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNC_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNC_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [FUNC_W-1:0] FN_SLTU = 6'b101011;
    localparam logic [FUNC_W-1:0] FN_JALR = 6'b011111;  // Local encoding, not MIPS-I

    localparam logic [1:0] ALUOP_ADD  = 2'b00;
    localparam logic [1:0] ALUOP_SUB  = 2'b01;
    localparam logic [1:0] ALUOP_FUNC = 2'b10;
    localparam logic [1:0] ALUOP_IMM  = 2'b11;

    localparam logic [1:0] ALUSRC_REG   = 2'b00;
    localparam logic [1:0] ALUSRC_IMM   = 2'b01;
    localparam logic [1:0] ALUSRC_SHAMT = 2'b10;

    localparam logic [1:0] WIDTH_BYTE = 2'b00;
    localparam logic [1:0] WIDTH_HALF = 2'b01;
    localparam logic [1:0] WIDTH_WORD = 2'b11;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef union packed {
        struct packed {
            logic [OP_W-1:0]       opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            logic [FUNC_W-1:0]     func;
        } r_view;
        struct packed {
            logic [OP_W-1:0]       opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm16;
        } i_view;
    } instr_t;

endpackage

// ==== decode/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit (
    input  mips_pkg::instr_t                i_instruction,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rs, o_rt, o_rd,
    output logic [mips_pkg::OP_W-1:0]       o_opcode,
    output logic [mips_pkg::FUNC_W-1:0]     o_func,
    output logic [mips_pkg::DATA_W-1:0]     o_immediate,
    output logic                            o_branch, o_reg_dst, o_mem2reg,
    output logic                            o_mem_read, o_mem_write,
    output logic                            o_immediate_flag, o_reg_write, o_sign_flag,
    output logic [1:0]                      o_alu_src, o_alu_op, o_width
);
    import mips_pkg::*;

    logic        r_type;
    logic [15:0] imm16;

    assign r_type   = (i_instruction.r_view.opcode == OP_RTYPE);
    assign imm16    = i_instruction.i_view.imm16;
    assign o_opcode = i_instruction.i_view.opcode;
    assign o_rs     = i_instruction.i_view.rs;
    assign o_rt     = i_instruction.i_view.rt;
    assign o_rd     = r_type ? i_instruction.r_view.rd : '0;    // Only R-type has rd/func
    assign o_func   = r_type ? i_instruction.r_view.func : '0;

    always_comb begin
        case (o_opcode)
            OP_ANDI, OP_ORI, OP_XORI: o_immediate = {16'b0, imm16};
            OP_LUI:                   o_immediate = {imm16, 16'b0};
            default:                  o_immediate = {{16{imm16[15]}}, imm16};
        endcase
    end

    always_comb begin
        o_branch         = 1'b0;
        o_reg_dst        = 1'b0;
        o_mem2reg        = 1'b0;
        o_mem_read       = 1'b0;
        o_mem_write      = 1'b0;
        o_immediate_flag = 1'b0;
        o_reg_write      = 1'b0;
        o_sign_flag      = 1'b0;
        o_alu_src        = ALUSRC_REG;
        o_alu_op         = ALUOP_ADD;
        o_width          = WIDTH_BYTE;
        case (o_opcode)
            OP_RTYPE: begin
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
                case (o_func)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        o_alu_src = ALUSRC_SHAMT;
                        o_alu_op  = ALUOP_FUNC;
                    end
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
                        o_alu_op = ALUOP_FUNC;
                    FN_JALR: o_alu_op = ALUOP_ADD;  // PC+4 plus 4
                    default: o_reg_write = 1'b0;
                endcase
            end
            OP_JAL:   o_reg_write = 1'b1;           // rt becomes r31 in ID/EX
            OP_BEQ, OP_BNE: begin
                o_branch = 1'b1;
                o_alu_op = ALUOP_SUB;
            end
            OP_ADDIU: begin
                o_reg_write = 1'b1;
                o_alu_src   = ALUSRC_IMM;
            end
            OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                o_reg_write      = 1'b1;
                o_immediate_flag = 1'b1;
                o_alu_src        = ALUSRC_IMM;
                o_alu_op         = ALUOP_IMM;
            end
            OP_LW: begin
                o_reg_write = 1'b1;
                o_mem2reg   = 1'b1;
                o_mem_read  = 1'b1;
                o_sign_flag = 1'b1;
                o_alu_src   = ALUSRC_IMM;
                o_width     = WIDTH_WORD;
            end
            OP_SW: begin
                o_mem_write = 1'b1;
                o_alu_src   = ALUSRC_IMM;
                o_width     = WIDTH_WORD;
            end
            default: ;
        endcase
    end

endmodule

// ==== decode/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_read_addr_a, i_read_addr_b,
    input  logic                            i_write_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_write_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_write_data,
    output logic [mips_pkg::DATA_W-1:0]     o_read_data_a, o_read_data_b
);
    import mips_pkg::*;

    logic [DATA_W-1:0] regs [2**REG_ADDR_W];
    logic              hit_a, hit_b;

    always_ff @(posedge clk or negedge i_reset) begin
        if (!i_reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write_en && (i_write_addr != '0)) begin
            regs[i_write_addr] <= i_write_data;
        end
    end

    // Write-to-read bypass, r0 never bypassed
    assign hit_a = i_write_en && (i_write_addr != '0) && (i_write_addr == i_read_addr_a);
    assign hit_b = i_write_en && (i_write_addr != '0) && (i_write_addr == i_read_addr_b);

    assign o_read_data_a = hit_a ? i_write_data : regs[i_read_addr_a];
    assign o_read_data_b = hit_b ? i_write_data : regs[i_read_addr_b];

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic [mips_pkg::DATA_W-1:0] i_operand_a, i_operand_b,
    input  logic [1:0]                  i_alu_op,
    input  logic [mips_pkg::OP_W-1:0]   i_opcode,
    input  logic [mips_pkg::FUNC_W-1:0] i_func,
    input  logic [4:0]                  i_shamt,
    output logic [mips_pkg::DATA_W-1:0] o_result
);
    import mips_pkg::*;

    logic lt_signed, lt_unsigned;

    assign lt_signed   = $signed(i_operand_a) < $signed(i_operand_b);
    assign lt_unsigned = i_operand_a < i_operand_b;

    always_comb begin
        o_result = '0;
        case (i_alu_op)
            ALUOP_ADD: o_result = i_operand_a + i_operand_b;
            ALUOP_SUB: o_result = i_operand_a - i_operand_b;
            ALUOP_FUNC: begin
                case (i_func)
                    FN_ADDU: o_result = i_operand_a + i_operand_b;
                    FN_SUBU: o_result = i_operand_a - i_operand_b;
                    FN_AND:  o_result = i_operand_a & i_operand_b;
                    FN_OR:   o_result = i_operand_a | i_operand_b;
                    FN_XOR:  o_result = i_operand_a ^ i_operand_b;
                    FN_NOR:  o_result = ~(i_operand_a | i_operand_b);
                    FN_SLT:  o_result = DATA_W'(lt_signed);
                    FN_SLTU: o_result = DATA_W'(lt_unsigned);
                    FN_SLL:  o_result = i_operand_a << i_shamt;
                    FN_SRL:  o_result = i_operand_a >> i_shamt;
                    FN_SRA:  o_result = $signed(i_operand_a) >>> i_shamt;
                    default: o_result = '0;
                endcase
            end
            default: begin                      // Immediate class, by opcode
                case (i_opcode)
                    OP_SLTI: o_result = DATA_W'(lt_signed);
                    OP_ANDI: o_result = i_operand_a & i_operand_b;
                    OP_ORI:  o_result = i_operand_a | i_operand_b;
                    OP_XORI: o_result = i_operand_a ^ i_operand_b;
                    OP_LUI:  o_result = i_operand_b;   // Already in upper half
                    default: o_result = '0;
                endcase
            end
        endcase
    end

endmodule

// ==== execute/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit (
    input  logic [mips_pkg::DATA_W-1:0]     i_reg_da, i_reg_db, i_immediate,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd, i_rs, i_rt,
    input  logic [mips_pkg::OP_W-1:0]       i_opcode,
    input  logic [mips_pkg::FUNC_W-1:0]     i_func,
    input  logic [4:0]                      i_shamt,
    input  logic                            i_reg_dst, i_immediate_flag,
    input  logic [1:0]                      i_alu_src, i_alu_op,
    input  logic                            i_fwd_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_fwd_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_fwd_data,
    output logic [mips_pkg::DATA_W-1:0]     o_alu_result, o_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_dest_reg,
    output logic                            o_zero
);
    import mips_pkg::*;

    logic              is_link, fwd_a, fwd_b;
    logic [DATA_W-1:0] reg_a, reg_b, op_a, op_b;

    // Operand B of a link holds the constant 4, never forwarded
    assign is_link = (i_opcode == OP_JAL) || ((i_opcode == OP_RTYPE) && (i_func == FN_JALR));
    assign fwd_a   = i_fwd_en && (i_fwd_addr != '0) && (i_fwd_addr == i_rs);
    assign fwd_b   = i_fwd_en && (i_fwd_addr != '0) && (i_fwd_addr == i_rt) && !is_link;
    assign reg_a   = fwd_a ? i_fwd_data : i_reg_da;
    assign reg_b   = fwd_b ? i_fwd_data : i_reg_db;

    always_comb begin
        op_a = reg_a;
        case (i_alu_src)
            ALUSRC_IMM:   op_b = i_immediate;
            ALUSRC_SHAMT: begin
                op_a = reg_b;                   // Shifts act on rt
                op_b = DATA_W'(i_shamt);
            end
            default:      op_b = reg_b;
        endcase
    end

    alu u_alu (
        .i_operand_a(op_a), .i_operand_b(op_b),
        .i_alu_op(i_immediate_flag ? ALUOP_IMM : i_alu_op),
        .i_opcode(i_opcode), .i_func(i_func), .i_shamt(i_shamt),
        .o_result(o_alu_result)
    );

    assign o_store_data = reg_b;
    assign o_dest_reg   = i_reg_dst ? i_rd : i_rt;
    assign o_zero       = (reg_a == reg_b) ^ (i_opcode == OP_BNE);

endmodule

// ==== source/id_ex_register.sv ====
`timescale 1ns/10ps

module id_ex_register (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_halt,
    input  logic                            i_stall,
    input  logic [mips_pkg::DATA_W-1:0]     i_read_data_a, i_read_data_b,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd, i_rs, i_rt,
    input  logic [mips_pkg::OP_W-1:0]       i_opcode,
    input  logic [mips_pkg::FUNC_W-1:0]     i_func,
    input  logic [mips_pkg::DATA_W-1:0]     i_immediate,
    input  mips_pkg::instr_t                i_instruction,
    input  logic [mips_pkg::DATA_W-1:0]     i_pcounter4,
    input  logic                            i_branch, i_reg_dst, i_mem2reg,
    input  logic                            i_mem_read, i_mem_write,
    input  logic                            i_immediate_flag, i_reg_write, i_sign_flag,
    input  logic [1:0]                      i_alu_src, i_alu_op, i_width,

    output logic [mips_pkg::DATA_W-1:0]     o_reg_da, o_reg_db,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rd, o_rs, o_rt,
    output logic [mips_pkg::OP_W-1:0]       o_opcode,
    output logic [mips_pkg::FUNC_W-1:0]     o_func,
    output logic [4:0]                      o_shamt,
    output logic [mips_pkg::DATA_W-1:0]     o_immediate,
    output logic                            o_branch, o_reg_dst, o_mem2reg,
    output logic                            o_mem_read, o_mem_write,
    output logic                            o_immediate_flag, o_reg_write, o_sign_flag,
    output logic [1:0]                      o_alu_src, o_alu_op, o_width
);
    import mips_pkg::*;

    logic is_jal;
    logic is_link;

    assign is_jal  = (i_opcode == OP_JAL);
    assign is_link = is_jal || ((i_opcode == OP_RTYPE) && (i_func == FN_JALR));

    always_ff @(posedge clk or negedge i_reset) begin
        if (!i_reset) begin
            o_reg_da         <= '0;
            o_reg_db         <= '0;
            o_rd             <= '0;
            o_rs             <= '0;
            o_rt             <= '0;
            o_opcode         <= '0;
            o_func           <= '0;
            o_shamt          <= '0;
            o_immediate      <= '0;
            o_branch         <= 1'b0;
            o_reg_dst        <= 1'b0;
            o_mem2reg        <= 1'b0;
            o_mem_read       <= 1'b0;
            o_mem_write      <= 1'b0;
            o_immediate_flag <= 1'b0;
            o_reg_write      <= 1'b0;
            o_sign_flag      <= 1'b0;
            o_alu_src        <= 2'b00;
            o_alu_op         <= 2'b00;
            o_width          <= 2'b00;
        end else if (!i_halt) begin
            // Link instructions compute PC+4 + 4 in the ALU
            o_reg_da    <= is_link ? i_pcounter4 : i_read_data_a;
            o_reg_db    <= is_link ? DATA_W'(4) : i_read_data_b;
            o_rs        <= is_link ? '0 : i_rs;
            o_rt        <= is_jal ? LINK_REG : i_rt;
            o_rd        <= i_rd;
            o_opcode    <= i_opcode;
            o_func      <= i_func;
            o_shamt     <= i_instruction.r_view.shamt;
            o_immediate <= i_immediate;

            // ##########################################################################
            // Stall turns the entry into a bubble
            o_branch         <= i_branch && !i_stall;
            o_reg_dst        <= i_reg_dst && !i_stall;
            o_mem2reg        <= i_mem2reg && !i_stall;
            o_mem_read       <= i_mem_read && !i_stall;
            o_mem_write      <= i_mem_write && !i_stall;
            o_immediate_flag <= i_immediate_flag && !i_stall;
            o_reg_write      <= i_reg_write && !i_stall;
            o_sign_flag      <= i_sign_flag && !i_stall;
            o_alu_src        <= i_stall ? 2'b00 : i_alu_src;
            o_alu_op         <= i_stall ? 2'b00 : i_alu_op;
            o_width          <= i_stall ? 2'b00 : i_width;
        end
    end

endmodule

// ==== source/result_register.sv ====
`timescale 1ns/10ps

module result_register (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_halt,
    input  logic [mips_pkg::DATA_W-1:0]     i_alu_result, i_store_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dest_reg,
    input  logic                            i_zero, i_reg_write, i_mem2reg,
    input  logic                            i_mem_read, i_mem_write, i_branch, i_sign_flag,
    input  logic [1:0]                      i_width,
    output logic [mips_pkg::DATA_W-1:0]     o_alu_result, o_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_write_reg,
    output logic                            o_reg_write, o_mem2reg, o_mem_read, o_mem_write,
    output logic                            o_branch, o_zero, o_sign_flag,
    output logic [1:0]                      o_width,
    output logic                            o_wb_en
);

    always_ff @(posedge clk or negedge i_reset) begin
        if (!i_reset) begin
            o_alu_result <= '0;
            o_store_data <= '0;
            o_write_reg  <= '0;
            o_reg_write  <= 1'b0;
            o_mem2reg    <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_branch     <= 1'b0;
            o_zero       <= 1'b0;
            o_sign_flag  <= 1'b0;
            o_width      <= 2'b00;
        end else if (!i_halt) begin
            o_alu_result <= i_alu_result;
            o_store_data <= i_store_data;
            o_write_reg  <= i_dest_reg;
            o_reg_write  <= i_reg_write;
            o_mem2reg    <= i_mem2reg;
            o_mem_read   <= i_mem_read;
            o_mem_write  <= i_mem_write;
            o_branch     <= i_branch;
            o_zero       <= i_zero;
            o_sign_flag  <= i_sign_flag;
            o_width      <= i_width;
        end
    end

    // Loads finish outside this slice
    assign o_wb_en = o_reg_write && !o_mem2reg && !i_halt;

endmodule

// ==== source/pipeline_top.sv ====
`timescale 1ns/10ps

module pipeline_top (
    input  logic                            clk,
    input  logic                            i_reset,
    input  mips_pkg::instr_t                i_instruction,
    input  logic [mips_pkg::DATA_W-1:0]     i_pcounter4,
    input  logic                            i_stall,
    input  logic                            i_halt,
    output logic [mips_pkg::DATA_W-1:0]     o_alu_result, o_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_write_reg,
    output logic                            o_reg_write, o_mem2reg, o_mem_read, o_mem_write,
    output logic                            o_branch, o_zero, o_sign_flag,
    output logic [1:0]                      o_width
);
    import mips_pkg::*;

    // ##########################################################################
    // Decode stage
    logic [REG_ADDR_W-1:0] d_rs, d_rt, d_rd;
    logic [OP_W-1:0]       d_opcode;
    logic [FUNC_W-1:0]     d_func;
    logic [DATA_W-1:0]     d_immediate, rf_data_a, rf_data_b;
    logic                  d_branch, d_reg_dst, d_mem2reg, d_mem_read, d_mem_write;
    logic                  d_immediate_flag, d_reg_write, d_sign_flag;
    logic [1:0]            d_alu_src, d_alu_op, d_width;

    // Execute stage
    logic [DATA_W-1:0]     x_reg_da, x_reg_db, x_immediate;
    logic [REG_ADDR_W-1:0] x_rd, x_rs, x_rt;
    logic [OP_W-1:0]       x_opcode;
    logic [FUNC_W-1:0]     x_func;
    logic [4:0]            x_shamt;
    logic                  x_branch, x_reg_dst, x_mem2reg, x_mem_read, x_mem_write;
    logic                  x_immediate_flag, x_reg_write, x_sign_flag;
    logic [1:0]            x_alu_src, x_alu_op, x_width;

    logic [DATA_W-1:0]     e_alu_result, e_store_data;
    logic [REG_ADDR_W-1:0] e_dest_reg;
    logic                  e_zero, wb_en;

    decode_unit u_decode (
        .i_instruction(i_instruction),
        .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd), .o_opcode(d_opcode), .o_func(d_func),
        .o_immediate(d_immediate), .o_branch(d_branch), .o_reg_dst(d_reg_dst),
        .o_mem2reg(d_mem2reg), .o_mem_read(d_mem_read), .o_mem_write(d_mem_write),
        .o_immediate_flag(d_immediate_flag), .o_reg_write(d_reg_write),
        .o_sign_flag(d_sign_flag), .o_alu_src(d_alu_src), .o_alu_op(d_alu_op),
        .o_width(d_width)
    );

    register_file u_regfile (
        .clk(clk), .i_reset(i_reset),
        .i_read_addr_a(d_rs), .i_read_addr_b(d_rt),
        .i_write_en(wb_en), .i_write_addr(o_write_reg), .i_write_data(o_alu_result),
        .o_read_data_a(rf_data_a), .o_read_data_b(rf_data_b)
    );

    id_ex_register u_id_ex (
        .clk(clk), .i_reset(i_reset), .i_halt(i_halt), .i_stall(i_stall),
        .i_read_data_a(rf_data_a), .i_read_data_b(rf_data_b),
        .i_rd(d_rd), .i_rs(d_rs), .i_rt(d_rt), .i_opcode(d_opcode), .i_func(d_func),
        .i_immediate(d_immediate), .i_instruction(i_instruction), .i_pcounter4(i_pcounter4),
        .i_branch(d_branch), .i_reg_dst(d_reg_dst), .i_mem2reg(d_mem2reg),
        .i_mem_read(d_mem_read), .i_mem_write(d_mem_write),
        .i_immediate_flag(d_immediate_flag), .i_reg_write(d_reg_write),
        .i_sign_flag(d_sign_flag), .i_alu_src(d_alu_src), .i_alu_op(d_alu_op),
        .i_width(d_width),
        .o_reg_da(x_reg_da), .o_reg_db(x_reg_db), .o_rd(x_rd), .o_rs(x_rs), .o_rt(x_rt),
        .o_opcode(x_opcode), .o_func(x_func), .o_shamt(x_shamt), .o_immediate(x_immediate),
        .o_branch(x_branch), .o_reg_dst(x_reg_dst), .o_mem2reg(x_mem2reg),
        .o_mem_read(x_mem_read), .o_mem_write(x_mem_write),
        .o_immediate_flag(x_immediate_flag), .o_reg_write(x_reg_write),
        .o_sign_flag(x_sign_flag), .o_alu_src(x_alu_src), .o_alu_op(x_alu_op),
        .o_width(x_width)
    );

    execute_unit u_execute (
        .i_reg_da(x_reg_da), .i_reg_db(x_reg_db), .i_immediate(x_immediate),
        .i_rd(x_rd), .i_rs(x_rs), .i_rt(x_rt), .i_opcode(x_opcode), .i_func(x_func),
        .i_shamt(x_shamt), .i_reg_dst(x_reg_dst), .i_immediate_flag(x_immediate_flag),
        .i_alu_src(x_alu_src), .i_alu_op(x_alu_op),
        .i_fwd_en(wb_en), .i_fwd_addr(o_write_reg), .i_fwd_data(o_alu_result),
        .o_alu_result(e_alu_result), .o_store_data(e_store_data),
        .o_dest_reg(e_dest_reg), .o_zero(e_zero)
    );

    result_register u_result (
        .clk(clk), .i_reset(i_reset), .i_halt(i_halt),
        .i_alu_result(e_alu_result), .i_store_data(e_store_data), .i_dest_reg(e_dest_reg),
        .i_zero(e_zero), .i_reg_write(x_reg_write), .i_mem2reg(x_mem2reg),
        .i_mem_read(x_mem_read), .i_mem_write(x_mem_write), .i_branch(x_branch),
        .i_sign_flag(x_sign_flag), .i_width(x_width),
        .o_alu_result(o_alu_result), .o_store_data(o_store_data), .o_write_reg(o_write_reg),
        .o_reg_write(o_reg_write), .o_mem2reg(o_mem2reg), .o_mem_read(o_mem_read),
        .o_mem_write(o_mem_write), .o_branch(o_branch), .o_zero(o_zero),
        .o_sign_flag(o_sign_flag), .o_width(o_width), .o_wb_en(wb_en)
    );

endmodule

// ==== test/tb_pipeline.sv ====
`timescale 1ns/10ps

module tb_pipeline;
    import mips_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_VEC      = 256;
    localparam string GOLDEN_FILE  = "test/pipeline_golden.txt";

    logic                  clk;
    logic                  i_reset;
    instr_t                i_instruction;
    logic [DATA_W-1:0]     i_pcounter4;
    logic                  i_stall;
    logic                  i_halt;
    logic [DATA_W-1:0]     o_alu_result, o_store_data;
    logic [REG_ADDR_W-1:0] o_write_reg;
    logic                  o_reg_write, o_mem2reg, o_mem_read, o_mem_write;
    logic                  o_branch, o_zero, o_sign_flag;
    logic [1:0]            o_width;

    // Golden vectors, one entry per cycle
    logic [DATA_W-1:0]     vec_instr [MAX_VEC];
    logic [DATA_W-1:0]     vec_pc4   [MAX_VEC];
    logic                  vec_stall [MAX_VEC];
    logic                  vec_halt  [MAX_VEC];
    logic [DATA_W-1:0]     exp_alu   [MAX_VEC];
    logic [DATA_W-1:0]     exp_store [MAX_VEC];
    logic [REG_ADDR_W-1:0] exp_wreg  [MAX_VEC];
    logic                  exp_rw    [MAX_VEC];
    logic                  exp_mr    [MAX_VEC];
    logic                  exp_mw    [MAX_VEC];
    logic                  exp_br    [MAX_VEC];
    logic                  exp_zero  [MAX_VEC];
    int                    num_vec = 0;

    pipeline_top u_dut (
        .clk(clk), .i_reset(i_reset), .i_instruction(i_instruction),
        .i_pcounter4(i_pcounter4), .i_stall(i_stall), .i_halt(i_halt),
        .o_alu_result(o_alu_result), .o_store_data(o_store_data), .o_write_reg(o_write_reg),
        .o_reg_write(o_reg_write), .o_mem2reg(o_mem2reg), .o_mem_read(o_mem_read),
        .o_mem_write(o_mem_write), .o_branch(o_branch), .o_zero(o_zero),
        .o_sign_flag(o_sign_flag), .o_width(o_width)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ########################################################################
    // Compare tasks
    task automatic check_word(input string name, input logic [DATA_W-1:0] exp_val,
                              input logic [DATA_W-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
            $display("TESTBENCH FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] exp_val,
                             input logic [REG_ADDR_W-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            $display("TESTBENCH FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp_val, act_val);
            $display("TESTBENCH FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_width(input string name, input logic [1:0] exp_val,
                               input logic [1:0] act_val);
        if (act_val !== exp_val) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp_val, act_val);
            $display("TESTBENCH FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic load_golden();
        int                    fd;
        int                    code;
        int                    fields;
        int                    line_no;
        string                 line;
        logic [DATA_W-1:0]     t_instr, t_pc4, t_alu, t_store;
        logic [REG_ADDR_W-1:0] t_wreg;
        logic                  t_stall, t_halt, t_rw, t_mr, t_mw, t_br, t_zero;
        line_no = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open golden file %s", GOLDEN_FILE);
            $display("TESTBENCH FAILED");
            $fatal(1, "Missing golden file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            line_no++;
            if (line.getc(0) == "#") continue;    // Column header
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                             t_instr, t_pc4, t_stall, t_halt, t_alu, t_store,
                             t_wreg, t_rw, t_mr, t_mw, t_br, t_zero);
            if (fields == 12 && num_vec < MAX_VEC) begin
                vec_instr[num_vec] = t_instr;
                vec_pc4[num_vec]   = t_pc4;
                vec_stall[num_vec] = t_stall;
                vec_halt[num_vec]  = t_halt;
                exp_alu[num_vec]   = t_alu;
                exp_store[num_vec] = t_store;
                exp_wreg[num_vec]  = t_wreg;
                exp_rw[num_vec]    = t_rw;
                exp_mr[num_vec]    = t_mr;
                exp_mw[num_vec]    = t_mw;
                exp_br[num_vec]    = t_br;
                exp_zero[num_vec]  = t_zero;
                num_vec++;
            end else if (fields > 0) begin
                $display("Golden file line %0d is incomplete", line_no);
                $display("TESTBENCH FAILED");
                $fatal(1, "Short golden line");
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("Golden file %s holds no vectors", GOLDEN_FILE);
            $display("TESTBENCH FAILED");
            $fatal(1, "Empty golden file");
        end
    endtask

    task automatic check_outputs(input int k);
        check_word("o_alu_result", exp_alu[k], o_alu_result);
        check_word("o_store_data", exp_store[k], o_store_data);
        check_reg("o_write_reg", exp_wreg[k], o_write_reg);
        check_flag("o_reg_write", exp_rw[k], o_reg_write);
        check_flag("o_mem_read", exp_mr[k], o_mem_read);
        check_flag("o_mem_write", exp_mw[k], o_mem_write);
        check_flag("o_branch", exp_br[k], o_branch);
        check_flag("o_zero", exp_zero[k], o_zero);
        // LW is the only load, a signed word access
        check_flag("o_mem2reg", exp_mr[k], o_mem2reg);
        check_flag("o_sign_flag", exp_mr[k], o_sign_flag);
        check_width("o_width", (exp_mr[k] || exp_mw[k]) ? WIDTH_WORD : WIDTH_BYTE, o_width);
    endtask

    // ########################################################################
    // Main sequence
    initial begin
        i_reset       = 1'b0;
        i_instruction = '0;
        i_pcounter4   = '0;
        i_stall       = 1'b0;
        i_halt        = 1'b0;
        load_golden();
        repeat (RESET_CYCLES) @(negedge clk);
        i_reset = 1'b1;
        for (int k = 0; k < num_vec; k++) begin
            if (k > 0) @(negedge clk);
            check_outputs(k);                     // Outputs before this line is driven
            i_instruction = vec_instr[k];
            i_pcounter4   = vec_pc4[k];
            i_stall       = vec_stall[k];
            i_halt        = vec_halt[k];
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (num_vec > 0);
        #((num_vec + RESET_CYCLES) * CLK_PERIOD + 100);
        $display("Timeout: the run did not reach its end in time");
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== test/pipeline_golden.txt ====
# instr pc4 stall halt | expected before drive: alu_result store_data write_reg
# reg_write mem_read mem_write branch zero (all hex)
24010005 00000104 0 0 00000000 00000000 00 0 0 0 0 0
2422FFFD 00000108 0 0 00000000 00000000 00 0 0 0 0 1
3C031234 0000010C 0 0 00000005 00000000 01 1 0 0 0 1
34635678 00000110 0 0 00000002 00000000 02 1 0 0 0 0
00222021 00000114 0 0 12340000 00000000 03 1 0 0 0 1
00442823 00000118 0 0 12345678 12340000 03 1 0 0 0 1
00653024 0000011C 0 0 00000007 00000002 04 1 0 0 0 0
00223825 00000120 0 0 FFFFFFFB 00000007 05 1 0 0 0 0
00664026 00000124 0 0 12345678 FFFFFFFB 06 1 0 0 0 0
00014827 00000128 0 0 00000007 00000002 07 1 0 0 0 0
00A1502A 0000012C 0 0 00000000 12345678 08 1 0 0 0 1
00A1502B 00000130 0 0 FFFFFFFA 00000005 09 1 0 0 0 0
00035900 00000134 0 0 00000001 00000005 0A 1 0 0 0 0
00056043 00000138 0 0 00000000 00000005 0A 1 0 0 0 0
00056F02 0000013C 0 0 23456780 12345678 0B 1 0 0 0 0
24200009 00000140 0 0 FFFFFFFD FFFFFFFB 0C 1 0 0 0 0
00007021 00000144 0 0 0000000F FFFFFFFB 0D 1 0 0 0 0
0C000040 00000148 0 0 0000000E 00000000 00 1 0 0 0 0
03E0781F 0000014C 0 0 00000000 00000000 0E 1 0 0 0 1
AC230008 00000150 0 0 0000014C 00000004 1F 1 0 0 0 0
8C45FFFC 00000154 0 0 00000150 00000004 0F 1 0 0 0 0
00A08021 00000158 0 0 0000000D 12345678 03 0 0 1 0 0
10870010 0000015C 0 0 FFFFFFFE FFFFFFFB 05 1 1 0 0 0
14870010 00000160 0 0 FFFFFFFB 00000000 10 1 0 0 0 0
24010064 00000164 1 0 00000000 00000007 07 0 0 0 1 1
24310000 00000168 0 0 00000000 00000007 07 0 0 0 1 0
24320001 0000016C 0 0 00000005 00000005 01 0 0 0 0 0
00000000 00000170 0 1 00000005 00000000 11 1 0 0 0 0
00000000 00000174 0 1 00000005 00000000 11 1 0 0 0 0
26530001 00000178 0 0 00000005 00000000 11 1 0 0 0 0
00000000 0000017C 0 0 00000006 00000000 12 1 0 0 0 0
00000000 00000180 0 0 00000007 00000000 13 1 0 0 0 0
00000000 00000184 0 0 00000000 00000000 00 1 0 0 0 1

// ==== all.f ====
common/mips_pkg.sv
decode/decode_unit.sv
decode/register_file.sv
execute/alu.sv
execute/execute_unit.sv
source/id_ex_register.sv
source/result_register.sv
source/pipeline_top.sv
test/tb_pipeline.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pipeline
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat all.f)
SIM_BIN := $(BUILD_DIR)/V$(TOP)
GOLDEN  := test/pipeline_golden.txt

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) all.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
